//--- all.f
hdl/alu_pkg.sv
hdl/alu_pipe_buf.sv
hdl/alu_decode_stage.sv
hdl/alu_exec_stage.sv
hdl/alu_flag_stage.sv
hdl/alu_pipe_top.sv
testbench/tb_clock.sv
testbench/alu_pipe_assert.sv
testbench/tb_alu_pipe.sv

//--- hdl/alu_decode_stage.sv
/*
 * decode stage
 * maps the opcode onto unit select, invert-b and sub-op
 * unknown opcodes are flagged illegal and steered to the logic unit,
 * which returns zero for them
 */
`timescale 1ns/100ps
`default_nettype none

module alu_decode_stage #(
   parameter bit BYPASS = 1'b1
) (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         in_valid,
   input  logic [alu_pkg::OP_W-1:0]     in_op,
   input  logic [alu_pkg::DATA_W-1:0]   in_a,
   input  logic [alu_pkg::DATA_W-1:0]   in_b,
   input  logic [alu_pkg::TAG_W-1:0]    in_tag,
   input  logic                         dec_ready,
   output logic                         in_ready,
   output logic                         dec_valid,
   output logic [alu_pkg::UNIT_W-1:0]   dec_unit,
   output logic                         dec_inv_b,
   output logic [alu_pkg::SUBOP_W-1:0]  dec_subop,
   output logic                         dec_ill,
   output logic [alu_pkg::DATA_W-1:0]   dec_a,
   output logic [alu_pkg::DATA_W-1:0]   dec_b,
   output logic [alu_pkg::TAG_W-1:0]    dec_tag
);

   alu_pkg::dec_item_t dec_d;   // decoded, not yet registered
   alu_pkg::dec_item_t dec_q;   // held in the buffer

   always_comb begin
      // defaults are the illegal-op decode
      dec_d.unit  = alu_pkg::UNIT_LOGIC;
      dec_d.inv_b = 1'b0;
      dec_d.subop = alu_pkg::SUBOP_NONE;
      dec_d.ill   = 1'b0;
      case (in_op)
         alu_pkg::OP_ADD: dec_d.unit = alu_pkg::UNIT_ADD;
         alu_pkg::OP_SUB: begin
            dec_d.unit  = alu_pkg::UNIT_ADD;
            dec_d.inv_b = 1'b1;   // a + ~b + 1
         end
         alu_pkg::OP_AND: dec_d.subop = alu_pkg::SUBOP_AND;
         alu_pkg::OP_OR:  dec_d.subop = alu_pkg::SUBOP_OR;
         alu_pkg::OP_XOR: dec_d.subop = alu_pkg::SUBOP_XOR;
         alu_pkg::OP_SLL: begin
            dec_d.unit  = alu_pkg::UNIT_SHIFT;
            dec_d.subop = alu_pkg::SUBOP_SLL;
         end
         alu_pkg::OP_SRL: begin
            dec_d.unit  = alu_pkg::UNIT_SHIFT;
            dec_d.subop = alu_pkg::SUBOP_SRL;
         end
         alu_pkg::OP_SRA: begin
            dec_d.unit  = alu_pkg::UNIT_SHIFT;
            dec_d.subop = alu_pkg::SUBOP_SRA;
         end
         default: dec_d.ill = 1'b1;   // 8..15, no trap
      endcase
      dec_d.a   = in_a;
      dec_d.b   = in_b;
      dec_d.tag = in_tag;
   end

   alu_pipe_buf #(
      .payload_t (alu_pkg::dec_item_t),
      .BYPASS    (BYPASS)
   ) u_buf (
      .clk       (clk),
      .rst       (rst),
      .din       (dec_d),
      .in_valid  (in_valid),
      .out_ready (dec_ready),
      .dout      (dec_q),
      .in_ready  (in_ready),
      .out_valid (dec_valid)
   );

   // unpack for the next stage
   assign dec_unit  = dec_q.unit;
   assign dec_inv_b = dec_q.inv_b;
   assign dec_subop = dec_q.subop;
   assign dec_ill   = dec_q.ill;
   assign dec_a     = dec_q.a;
   assign dec_b     = dec_q.b;
   assign dec_tag   = dec_q.tag;

endmodule

`default_nettype wire

//--- hdl/alu_exec_stage.sv
/*
 * execute stage
 * one adder, one logic unit and one shifter, result picked by unit select
 * carry is only meaningful from the adder, zero otherwise
 * shifts use b[4:0], so a shift by 32 is a shift by 0
 */
`timescale 1ns/100ps
`default_nettype none

module alu_exec_stage #(
   parameter bit BYPASS = 1'b1
) (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         dec_valid,
   input  logic [alu_pkg::UNIT_W-1:0]   dec_unit,
   input  logic                         dec_inv_b,
   input  logic [alu_pkg::SUBOP_W-1:0]  dec_subop,
   input  logic                         dec_ill,
   input  logic [alu_pkg::DATA_W-1:0]   dec_a,
   input  logic [alu_pkg::DATA_W-1:0]   dec_b,
   input  logic [alu_pkg::TAG_W-1:0]    dec_tag,
   input  logic                         exe_ready,
   output logic                         dec_ready,
   output logic                         exe_valid,
   output logic [alu_pkg::DATA_W-1:0]   exe_raw,
   output logic                         exe_carry,
   output logic                         exe_sa,
   output logic                         exe_sb,
   output logic [alu_pkg::UNIT_W-1:0]   exe_unit,
   output logic                         exe_ill,
   output logic [alu_pkg::TAG_W-1:0]    exe_tag
);

   logic [alu_pkg::DATA_W-1:0]  b_eff;       // b after optional invert
   logic [alu_pkg::DATA_W-1:0]  add_sum;
   logic                        add_carry;
   logic [alu_pkg::DATA_W-1:0]  logic_res;
   logic [alu_pkg::DATA_W-1:0]  shift_res;
   logic [alu_pkg::SHAMT_W-1:0] shamt;
   alu_pkg::exe_item_t          exe_d;
   alu_pkg::exe_item_t          exe_q;

   // **************************************************
   // adder
   // **************************************************
   assign b_eff = dec_inv_b ? ~dec_b : dec_b;
   // inv_b doubles as carry-in, giving two's complement SUB
   assign {add_carry, add_sum} = {1'b0, dec_a} + {1'b0, b_eff}
                               + {{alu_pkg::DATA_W{1'b0}}, dec_inv_b};

   // **************************************************
   // logic unit and shifter
   // **************************************************
   always_comb begin
      case (dec_subop)
         alu_pkg::SUBOP_AND: logic_res = dec_a & dec_b;
         alu_pkg::SUBOP_OR:  logic_res = dec_a | dec_b;
         alu_pkg::SUBOP_XOR: logic_res = dec_a ^ dec_b;
         default:            logic_res = '0;   // illegal op
      endcase
      if (dec_ill) begin
         logic_res = '0;
      end
   end

   assign shamt = dec_b[alu_pkg::SHAMT_W-1:0];

   always_comb begin
      case (dec_subop)
         alu_pkg::SUBOP_SLL: shift_res = dec_a << shamt;
         alu_pkg::SUBOP_SRL: shift_res = dec_a >> shamt;
         alu_pkg::SUBOP_SRA: shift_res = alu_pkg::DATA_W'($signed(dec_a) >>> shamt);
         default:            shift_res = '0;
      endcase
   end

   // result select and packing
   always_comb begin
      case (dec_unit)
         alu_pkg::UNIT_ADD:   exe_d.raw = add_sum;
         alu_pkg::UNIT_SHIFT: exe_d.raw = shift_res;
         default:             exe_d.raw = logic_res;
      endcase
      exe_d.carry = (dec_unit == alu_pkg::UNIT_ADD) ? add_carry : 1'b0;
      exe_d.sa    = dec_a[alu_pkg::DATA_W-1];
      exe_d.sb    = b_eff[alu_pkg::DATA_W-1];   // sign as the adder sees it
      exe_d.unit  = dec_unit;
      exe_d.ill   = dec_ill;
      exe_d.tag   = dec_tag;
   end

   alu_pipe_buf #(
      .payload_t (alu_pkg::exe_item_t),
      .BYPASS    (BYPASS)
   ) u_buf (
      .clk       (clk),
      .rst       (rst),
      .din       (exe_d),
      .in_valid  (dec_valid),
      .out_ready (exe_ready),
      .dout      (exe_q),
      .in_ready  (dec_ready),
      .out_valid (exe_valid)
   );

   assign exe_raw   = exe_q.raw;
   assign exe_carry = exe_q.carry;
   assign exe_sa    = exe_q.sa;
   assign exe_sb    = exe_q.sb;
   assign exe_unit  = exe_q.unit;
   assign exe_ill   = exe_q.ill;
   assign exe_tag   = exe_q.tag;

endmodule

`default_nettype wire

//--- hdl/alu_flag_stage.sv
/*
 * flag stage
 * Z and N come from the raw result, C and ILL pass through
 * V is only raised for the adder
 */
`timescale 1ns/100ps
`default_nettype none

module alu_flag_stage #(
   parameter bit BYPASS = 1'b1
) (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         exe_valid,
   input  logic [alu_pkg::DATA_W-1:0]   exe_raw,
   input  logic                         exe_carry,
   input  logic                         exe_sa,
   input  logic                         exe_sb,
   input  logic [alu_pkg::UNIT_W-1:0]   exe_unit,
   input  logic                         exe_ill,
   input  logic [alu_pkg::TAG_W-1:0]    exe_tag,
   input  logic                         out_ready,
   output logic                         exe_ready,
   output logic                         out_valid,
   output logic [alu_pkg::DATA_W-1:0]   out_result,
   output logic [alu_pkg::FLAG_W-1:0]   out_flags,
   output logic [alu_pkg::TAG_W-1:0]    out_tag
);

   logic [alu_pkg::FLAG_W-1:0] flags;
   logic                       res_sign;   // top bit of the result
   alu_pkg::res_item_t         res_d;
   alu_pkg::res_item_t         res_q;

   assign res_sign = exe_raw[alu_pkg::DATA_W-1];

   always_comb begin
      flags                     = '0;
      flags[alu_pkg::FLG_Z]     = (exe_raw == '0);
      flags[alu_pkg::FLG_N]     = res_sign;
      flags[alu_pkg::FLG_C]     = exe_carry;
      // same-sign inputs with a sign flip on the way out
      flags[alu_pkg::FLG_V]     = (exe_unit == alu_pkg::UNIT_ADD) &&
                                  (exe_sa == exe_sb) && (res_sign != exe_sa);
      flags[alu_pkg::FLG_ILL]   = exe_ill;
   end

   always_comb begin
      res_d.result = exe_raw;
      res_d.flags  = flags;
      res_d.tag    = exe_tag;
   end

   alu_pipe_buf #(
      .payload_t (alu_pkg::res_item_t),
      .BYPASS    (BYPASS)
   ) u_buf (
      .clk       (clk),
      .rst       (rst),
      .din       (res_d),
      .in_valid  (exe_valid),
      .out_ready (out_ready),
      .dout      (res_q),
      .in_ready  (exe_ready),
      .out_valid (out_valid)
   );

   assign out_result = res_q.result;
   assign out_flags  = res_q.flags;
   assign out_tag    = res_q.tag;

endmodule

`default_nettype wire

//--- hdl/alu_pipe_buf.sv
/*
 * one-slot pipe buffer on a valid/ready pair
 * upstream must hold din stable while in_valid is high and not yet taken
 * BYPASS 1 lets a full slot refill in the cycle it is popped,
 * BYPASS 0 halves throughput but breaks the ready path
 */
`timescale 1ns/100ps
`default_nettype none

module alu_pipe_buf #(
   parameter type payload_t = logic [0:0],   // stage payload struct
   parameter bit  BYPASS    = 1'b1           // refill while popping
) (
   input  logic     clk,
   input  logic     rst,
   input  payload_t din,
   input  logic     in_valid,
   input  logic     out_ready,
   output payload_t dout,
   output logic     in_ready,
   output logic     out_valid
);

   logic push;   // item taken from upstream
   logic pop;    // item handed downstream

   assign push = in_valid & in_ready;
   assign pop  = out_valid & out_ready;

   // slot occupancy, push wins over pop
   always_ff @(posedge clk) begin
      if (rst) begin
         out_valid <= 1'b0;
      end else if (push) begin
         out_valid <= 1'b1;
      end else if (pop) begin
         out_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         dout <= din;   // payload has no reset
      end
   end

   generate
      if (BYPASS) begin : g_bypass
         assign in_ready = ~out_valid | pop;   // free now or freed this cycle
      end else begin : g_no_bypass
         assign in_ready = ~out_valid;          // only when empty
      end
   endgenerate

endmodule

`default_nettype wire

//--- hdl/alu_pipe_top.sv
/*
 * three-stage ALU pipeline, decode -> execute -> flag
 * three edges from accept to result, up to three ops in flight
 * BYPASS 1 gives one op per cycle, BYPASS 0 one every two cycles
 * results leave in issue order
 */
`timescale 1ns/100ps
`default_nettype none

module alu_pipe_top #(
   parameter bit BYPASS = 1'b1   // passed to every stage buffer
) (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         in_valid,
   input  logic [alu_pkg::OP_W-1:0]     in_op,
   input  logic [alu_pkg::DATA_W-1:0]   in_a,
   input  logic [alu_pkg::DATA_W-1:0]   in_b,
   input  logic [alu_pkg::TAG_W-1:0]    in_tag,
   output logic                         in_ready,
   output logic                         out_valid,
   output logic [alu_pkg::DATA_W-1:0]   out_result,
   output logic [alu_pkg::FLAG_W-1:0]   out_flags,
   output logic [alu_pkg::TAG_W-1:0]    out_tag,
   input  logic                         out_ready
);

   // **************************************************
   // decode -> execute
   // **************************************************
   logic                         dec_valid, dec_ready;
   logic [alu_pkg::UNIT_W-1:0]   dec_unit;
   logic                         dec_inv_b;
   logic [alu_pkg::SUBOP_W-1:0]  dec_subop;
   logic                         dec_ill;
   logic [alu_pkg::DATA_W-1:0]   dec_a, dec_b;
   logic [alu_pkg::TAG_W-1:0]    dec_tag;

   // **************************************************
   // execute -> flag
   // **************************************************
   logic                         exe_valid, exe_ready;
   logic [alu_pkg::DATA_W-1:0]   exe_raw;
   logic                         exe_carry, exe_sa, exe_sb;
   logic [alu_pkg::UNIT_W-1:0]   exe_unit;
   logic                         exe_ill;
   logic [alu_pkg::TAG_W-1:0]    exe_tag;

   alu_decode_stage #(.BYPASS(BYPASS)) u_dec (
      .clk       (clk),        .rst       (rst),
      .in_valid  (in_valid),   .in_op     (in_op),
      .in_a      (in_a),       .in_b      (in_b),
      .in_tag    (in_tag),     .dec_ready (dec_ready),
      .in_ready  (in_ready),   .dec_valid (dec_valid),
      .dec_unit  (dec_unit),   .dec_inv_b (dec_inv_b),
      .dec_subop (dec_subop),  .dec_ill   (dec_ill),
      .dec_a     (dec_a),      .dec_b     (dec_b),
      .dec_tag   (dec_tag)
   );

   alu_exec_stage #(.BYPASS(BYPASS)) u_exe (
      .clk       (clk),        .rst       (rst),
      .dec_valid (dec_valid),  .dec_unit  (dec_unit),
      .dec_inv_b (dec_inv_b),  .dec_subop (dec_subop),
      .dec_ill   (dec_ill),    .dec_a     (dec_a),
      .dec_b     (dec_b),      .dec_tag   (dec_tag),
      .exe_ready (exe_ready),  .dec_ready (dec_ready),
      .exe_valid (exe_valid),  .exe_raw   (exe_raw),
      .exe_carry (exe_carry),  .exe_sa    (exe_sa),
      .exe_sb    (exe_sb),     .exe_unit  (exe_unit),
      .exe_ill   (exe_ill),    .exe_tag   (exe_tag)
   );

   alu_flag_stage #(.BYPASS(BYPASS)) u_flg (
      .clk        (clk),        .rst        (rst),
      .exe_valid  (exe_valid),  .exe_raw    (exe_raw),
      .exe_carry  (exe_carry),  .exe_sa     (exe_sa),
      .exe_sb     (exe_sb),     .exe_unit   (exe_unit),
      .exe_ill    (exe_ill),    .exe_tag    (exe_tag),
      .out_ready  (out_ready),  .exe_ready  (exe_ready),
      .out_valid  (out_valid),  .out_result (out_result),
      .out_flags  (out_flags),  .out_tag    (out_tag)
   );

endmodule

`default_nettype wire

//--- hdl/alu_pkg.sv
/*
 * shared widths, opcodes, flag bit positions and stage payloads
 * opcodes 8..15 are not decoded, they travel as illegal ops
 * no multiply or divide, no register file
 */
`default_nettype none

package alu_pkg;

   // **************************************************
   // widths
   // **************************************************
   localparam int DATA_W  = 32;   // operand and result width
   localparam int TAG_W   = 4;    // tag carried alongside each op
   localparam int OP_W    = 4;    // opcode width
   localparam int FLAG_W  = 5;    // flags field width
   localparam int UNIT_W  = 2;    // unit select width
   localparam int SUBOP_W = 2;    // sub-op width
   localparam int SHAMT_W = 5;    // shifts only look at the low bits of b

   // opcodes, anything above OP_SRA is illegal
   typedef enum logic [OP_W-1:0] {
      OP_ADD = 4'd0,
      OP_SUB = 4'd1,
      OP_AND = 4'd2,
      OP_OR  = 4'd3,
      OP_XOR = 4'd4,
      OP_SLL = 4'd5,
      OP_SRL = 4'd6,
      OP_SRA = 4'd7
   } op_e;

   // bit positions inside the flags field
   typedef enum logic [2:0] {
      FLG_Z   = 3'd0,   // zero result
      FLG_N   = 3'd1,   // negative result
      FLG_C   = 3'd2,   // adder carry out
      FLG_V   = 3'd3,   // signed overflow
      FLG_ILL = 3'd4    // illegal opcode
   } flag_e;

   // unit select
   localparam logic [UNIT_W-1:0] UNIT_ADD   = 2'd0;
   localparam logic [UNIT_W-1:0] UNIT_LOGIC = 2'd1;
   localparam logic [UNIT_W-1:0] UNIT_SHIFT = 2'd2;

   // sub-ops, meaning depends on the unit
   localparam logic [SUBOP_W-1:0] SUBOP_AND  = 2'd0;
   localparam logic [SUBOP_W-1:0] SUBOP_OR   = 2'd1;
   localparam logic [SUBOP_W-1:0] SUBOP_XOR  = 2'd2;
   localparam logic [SUBOP_W-1:0] SUBOP_SLL  = 2'd0;
   localparam logic [SUBOP_W-1:0] SUBOP_SRL  = 2'd1;
   localparam logic [SUBOP_W-1:0] SUBOP_SRA  = 2'd2;
   localparam logic [SUBOP_W-1:0] SUBOP_NONE = 2'd3;   // illegal ops land here

   // **************************************************
   // stage payloads
   // **************************************************
   typedef struct packed {
      logic [UNIT_W-1:0]  unit;
      logic               inv_b;    // set for SUB
      logic [SUBOP_W-1:0] subop;
      logic               ill;
      logic [DATA_W-1:0]  a;
      logic [DATA_W-1:0]  b;
      logic [TAG_W-1:0]   tag;
   } dec_item_t;

   typedef struct packed {
      logic [DATA_W-1:0]  raw;      // unit result before flags
      logic               carry;
      logic               sa;       // sign of a
      logic               sb;       // sign of effective b
      logic [UNIT_W-1:0]  unit;
      logic               ill;
      logic [TAG_W-1:0]   tag;
   } exe_item_t;

   typedef struct packed {
      logic [DATA_W-1:0]  result;
      logic [FLAG_W-1:0]  flags;
      logic [TAG_W-1:0]   tag;
   } res_item_t;

endpackage

`default_nettype wire

//--- run.sh
#!/bin/bash
# build and run the ALU pipeline testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_alu_pipe -o sim_alu -f all.f \
   || { echo "build failed"; exit 1; }

./obj_dir/sim_alu > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log

grep -q "TESTBENCH FAILED" sim.log && { echo "run failed"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "run ended without a result"; exit 1; }
echo "run passed"

//--- testbench/alu_pipe_assert.sv
/*
 * handshake checks bound into alu_pipe_top
 * a stalled stage must hold valid and data until it is taken
 * reset clears out_valid, in_ready is up once reset drops
 */
`timescale 1ns/100ps
`default_nettype none

module alu_pipe_assert (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         in_ready,
   input  logic                         dec_valid,
   input  logic                         dec_ready,
   input  logic [alu_pkg::UNIT_W-1:0]   dec_unit,
   input  logic                         dec_inv_b,
   input  logic [alu_pkg::SUBOP_W-1:0]  dec_subop,
   input  logic                         dec_ill,
   input  logic [alu_pkg::DATA_W-1:0]   dec_a,
   input  logic [alu_pkg::DATA_W-1:0]   dec_b,
   input  logic [alu_pkg::TAG_W-1:0]    dec_tag,
   input  logic                         exe_valid,
   input  logic                         exe_ready,
   input  logic [alu_pkg::DATA_W-1:0]   exe_raw,
   input  logic                         exe_carry,
   input  logic                         exe_sa,
   input  logic                         exe_sb,
   input  logic [alu_pkg::UNIT_W-1:0]   exe_unit,
   input  logic                         exe_ill,
   input  logic [alu_pkg::TAG_W-1:0]    exe_tag,
   input  logic                         out_valid,
   input  logic                         out_ready,
   input  logic [alu_pkg::DATA_W-1:0]   out_result,
   input  logic [alu_pkg::FLAG_W-1:0]   out_flags,
   input  logic [alu_pkg::TAG_W-1:0]    out_tag
);

   // **************************************************
   // stalled items stay put
   // **************************************************
   a_dec_hold : assert property (@(posedge clk) disable iff (rst)
      (dec_valid && !dec_ready) |=> dec_valid &&
      $stable({dec_unit, dec_inv_b, dec_subop, dec_ill, dec_a, dec_b, dec_tag}))
      else $error("decode item changed while stalled");

   a_exe_hold : assert property (@(posedge clk) disable iff (rst)
      (exe_valid && !exe_ready) |=> exe_valid &&
      $stable({exe_raw, exe_carry, exe_sa, exe_sb, exe_unit, exe_ill, exe_tag}))
      else $error("execute item changed while stalled");

   a_out_hold : assert property (@(posedge clk) disable iff (rst)
      (out_valid && !out_ready) |=> out_valid && $stable({out_result, out_flags, out_tag}))
      else $error("result changed while stalled");

   // **************************************************
   // reset behavior
   // **************************************************
   a_rst_empty : assert property (@(posedge clk) rst |=> !out_valid)
      else $error("out_valid high in reset");

   // first edge after reset, nothing in flight yet
   a_rst_ready : assert property (@(posedge clk)
      $fell(rst) |-> (in_ready && !dec_valid && !exe_valid && !out_valid))
      else $error("pipeline not empty or in_ready low after reset");

endmodule

`default_nettype wire

//--- testbench/alu_stimulus.txt
# columns, all hex: op a b tag expected_result expected_flags
# flag bits: 4 ill, 3 v, 2 c, 1 n, 0 z
0 00000001 00000002 0 00000003 00
0 ffffffff 00000001 1 00000000 05
0 7fffffff 00000001 2 80000000 0a
0 80000000 80000000 3 00000000 0d
1 00000005 00000003 4 00000002 04
1 00000003 00000005 5 fffffffe 02
1 12345678 12345678 6 00000000 05
1 80000000 00000001 7 7fffffff 0c
1 7fffffff ffffffff 8 80000000 0a
0 00000000 00000000 9 00000000 01
1 00000000 00000001 a ffffffff 02
2 f0f0f0f0 ff00ff00 b f000f000 02
3 0f0f0000 00f0f000 c 0ffff000 00
4 aaaaaaaa aaaaaaaa d 00000000 01
4 12345678 ffffffff e edcba987 02
5 00000001 0000001f f 80000000 02
5 00000003 00000000 0 00000003 00
5 0000000f 00000020 1 0000000f 00
5 ffffffff 00000024 2 fffffff0 02
6 80000000 0000001f 3 00000001 00
6 f0000000 00000004 4 0f000000 00
6 80000000 00000020 5 80000000 02
7 80000000 0000001f 6 ffffffff 02
7 80000000 00000020 7 80000000 02
7 7ffffff0 00000004 8 07ffffff 00
8 12345678 9abcdef0 9 00000000 11
9 ffffffff 00000001 a 00000000 11
a 00000000 00000000 b 00000000 11
c 80000000 80000000 c 00000000 11
f ffffffff ffffffff d 00000000 11

//--- testbench/tb_alu_pipe.sv
/*
 * testbench for alu_pipe_top, BYPASS 1
 * stimulus and expected result/flags come from testbench/alu_stimulus.txt,
 * run from the project root
 * pass 1 random input gaps and output stalls, pass 2 back-to-back burst
 * stops at the first mismatch or stall
 */
`timescale 1ns/100ps
`default_nettype none

module tb_alu_pipe;

   localparam string       STIM_FILE = "testbench/alu_stimulus.txt";
   localparam logic [31:0] LCG_SEED  = 32'h269f_555a;
   localparam int          TIMEOUT   = 200;   // cycles per wait
   localparam int          MAX_GAP   = 3;     // idle slots before one item

   logic                         clk, rst;
   logic                         in_valid, in_ready, out_valid, out_ready;
   logic [alu_pkg::OP_W-1:0]     in_op;
   logic [alu_pkg::DATA_W-1:0]   in_a, in_b, out_result;
   logic [alu_pkg::TAG_W-1:0]    in_tag, out_tag;
   logic [alu_pkg::FLAG_W-1:0]   out_flags;

   // stimulus table, one entry per file line
   logic [alu_pkg::OP_W-1:0]     stim_op[$];
   logic [alu_pkg::DATA_W-1:0]   stim_a[$], stim_b[$], stim_res[$];
   logic [alu_pkg::TAG_W-1:0]    stim_tag[$];
   logic [alu_pkg::FLAG_W-1:0]   stim_flags[$];

   int exp_q[$];        // indices accepted, oldest first
   int cyc       = 0;   // rising edge count
   int err_cnt   = 0;
   int burst_acc = 0;   // edge of first burst accept
   int first_out = 0;   // edge of first result of a pass

   tb_clock u_clk (.clk(clk), .rst(rst));

   alu_pipe_top #(.BYPASS(1'b1)) dut (
      .clk        (clk),        .rst        (rst),
      .in_valid   (in_valid),   .in_op      (in_op),
      .in_a       (in_a),       .in_b       (in_b),
      .in_tag     (in_tag),     .in_ready   (in_ready),
      .out_valid  (out_valid),  .out_result (out_result),
      .out_flags  (out_flags),  .out_tag    (out_tag),
      .out_ready  (out_ready)
   );

   bind alu_pipe_top alu_pipe_assert u_assert (
      .clk        (clk),        .rst        (rst),
      .in_ready   (in_ready),   .dec_valid  (dec_valid),
      .dec_ready  (dec_ready),  .dec_unit   (dec_unit),
      .dec_inv_b  (dec_inv_b),  .dec_subop  (dec_subop),
      .dec_ill    (dec_ill),    .dec_a      (dec_a),
      .dec_b      (dec_b),      .dec_tag    (dec_tag),
      .exe_valid  (exe_valid),  .exe_ready  (exe_ready),
      .exe_raw    (exe_raw),    .exe_carry  (exe_carry),
      .exe_sa     (exe_sa),     .exe_sb     (exe_sb),
      .exe_unit   (exe_unit),   .exe_ill    (exe_ill),
      .exe_tag    (exe_tag),    .out_valid  (out_valid),
      .out_ready  (out_ready),  .out_result (out_result),
      .out_flags  (out_flags),  .out_tag    (out_tag)
   );

   always @(posedge clk) cyc <= cyc + 1;   // readers at the edge see the old count

   // **************************************************
   // helpers
   // **************************************************
   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;   // numerical recipes constants
   endfunction

   task automatic fail_stop(input string msg);
      $display("%s", msg);
      $display("TESTBENCH FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      if (got !== exp) begin
         err_cnt++;
         fail_stop($sformatf("ERR %0d ns: %s got %h expected %h", $time, name, got, exp));
      end
   endtask

   task automatic load_stimulus();
      int          fd;
      int          code;
      string       line;
      logic [31:0] f_op, f_a, f_b, f_tag, f_res, f_flg;
      fd = $fopen(STIM_FILE, "r");
      if (fd == 0) fail_stop("cannot open the stimulus file");
      while (!$feof(fd)) begin
         line = "";
         code = $fgets(line, fd);
         if (code != 0 && line.len() > 1 && line.getc(0) != "#") begin   // skip notes
            code = $sscanf(line, "%h %h %h %h %h %h", f_op, f_a, f_b, f_tag, f_res, f_flg);
            if (code != 6) fail_stop({"malformed stimulus line: ", line});
            stim_op.push_back(f_op[alu_pkg::OP_W-1:0]);
            stim_a.push_back(f_a);
            stim_b.push_back(f_b);
            stim_tag.push_back(f_tag[alu_pkg::TAG_W-1:0]);
            stim_res.push_back(f_res);
            stim_flags.push_back(f_flg[alu_pkg::FLAG_W-1:0]);
         end
      end
      $fclose(fd);
      if (stim_op.size() == 0) fail_stop("stimulus file holds no operations");
   endtask

   task automatic wait_reset_done();
      int n;
      n = 0;
      @(posedge clk);
      while (rst) begin
         n++;
         if (n > TIMEOUT) fail_stop("reset was never released");
         @(posedge clk);
      end
   endtask

   // **************************************************
   // driver, one item per accept
   // **************************************************
   task automatic drive_all(input bit gaps);
      logic [31:0] rnd;
      int          wait_cnt;
      int          gap_cnt;
      rnd = LCG_SEED;
      for (int i = 0; i < stim_op.size(); i++) begin
         gap_cnt = 0;
         rnd = lcg_step(rnd);
         while (gaps && rnd[31:30] == 2'b00 && gap_cnt < MAX_GAP) begin   // ~1 in 4
            in_valid = 1'b0;
            @(negedge clk);
            gap_cnt++;
            rnd = lcg_step(rnd);
         end
         in_valid = 1'b1;
         in_op    = stim_op[i];
         in_a     = stim_a[i];
         in_b     = stim_b[i];
         in_tag   = stim_tag[i];
         wait_cnt = 0;
         @(posedge clk);
         while (!in_ready) begin   // item held until taken
            wait_cnt++;
            if (wait_cnt > TIMEOUT)
               fail_stop($sformatf("item %0d never accepted, in_ready stuck low", i));
            @(posedge clk);
         end
         exp_q.push_back(i);
         if (!gaps && i == 0) burst_acc = cyc;
         if (!gaps) check_val("burst in_ready stall cycles", 32'(wait_cnt), 32'd0);
         @(negedge clk);
      end
      in_valid = 1'b0;
   endtask

   // **************************************************
   // checker, in-order compare against the table
   // **************************************************
   task automatic collect_all(input bit stall);
      logic [31:0] rnd;
      int          got;
      int          idle;
      int          idx;
      rnd  = LCG_SEED;
      got  = 0;
      idle = 0;
      while (got < stim_op.size()) begin
         @(negedge clk);
         rnd = lcg_step(rnd);
         out_ready = stall ? (rnd[31:16] % 16'd3 != 16'd0) : 1'b1;   // low ~1 in 3
         @(posedge clk);
         if (out_valid && out_ready) begin
            if (exp_q.size() == 0) fail_stop("result appeared with no input pending");
            idx = exp_q.pop_front();
            check_val("out_result", out_result, stim_res[idx]);
            check_val("out_flags", 32'(out_flags), 32'(stim_flags[idx]));
            check_val("out_tag", 32'(out_tag), 32'(stim_tag[idx]));
            if (got == 0) first_out = cyc;
            got++;
            idle = 0;
         end else begin
            idle++;
            if (idle > TIMEOUT)
               fail_stop($sformatf("pipeline stalled after %0d results", got));
         end
      end
   endtask

   // nothing extra comes out once every result is in
   task automatic check_drained();
      for (int k = 0; k < 4; k++) begin
         @(posedge clk);
         check_val("out_valid after drain", 32'(out_valid), 32'd0);
      end
   endtask

   initial begin : main_seq
      in_valid  = 1'b0;
      in_op     = '0;
      in_a      = '0;
      in_b      = '0;
      in_tag    = '0;
      out_ready = 1'b0;
      load_stimulus();
      wait_reset_done();
      @(negedge clk);
      check_val("in_ready after reset", 32'(in_ready), 32'd1);
      check_val("out_valid after reset", 32'(out_valid), 32'd0);

      fork   // random gaps and back-pressure
         drive_all(1'b1);
         collect_all(1'b1);
      join
      check_drained();

      @(negedge clk);
      out_ready = 1'b1;
      fork   // back-to-back burst, output always ready
         drive_all(1'b0);
         collect_all(1'b0);
      join
      check_val("first result latency in edges", 32'(first_out - burst_acc), 32'd3);
      check_drained();

      if (err_cnt == 0) begin
         $display("TESTBENCH PASSED");
         $finish;
      end else begin
         fail_stop("mismatches were counted");
      end
   end

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
/*
 * testbench clock and reset source
 * 100 ns period, reset high for the first 8 rising edges
 * reset drops on a falling edge, away from the sampling edge
 */
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
   parameter int HALF_NS    = 50,   // half period in ns
   parameter int RST_CYCLES = 8     // rising edges held in reset
) (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #HALF_NS clk = ~clk;
   end

   initial begin
      rst = 1'b1;
      repeat (RST_CYCLES) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;   // released between edges
   end

endmodule

`default_nettype wire
